// File: rtl/lsu_pkg.sv
package lsu_pkg;

	localparam int XLEN     = 32;
	localparam int TAG_W    = 5;
	localparam int OFFSET_W = 16;

	typedef logic [TAG_W-1:0] rob_tag_t;

	typedef enum logic [1:0] {
		exc_none       = 2'd0,
		exc_misaligned = 2'd1,
		exc_page_fault = 2'd2
	} exc_code_t;

	typedef struct packed {
		logic            ready;
		rob_tag_t        tag;
		logic [XLEN-1:0] value;
	} operand_t;

	typedef struct packed {
		logic                       busy;
		logic                       is_store;
		operand_t                   base;
		operand_t                   sdata;
		logic signed [OFFSET_W-1:0] offset;
		rob_tag_t                   dest;
	} rs_entry_t;

	typedef struct packed {
		logic            valid;
		rob_tag_t        tag;
		logic [XLEN-1:0] value;
	} cdb_packet_t;

	typedef struct packed {
		logic [XLEN-1:0] paddr;
		logic            fault;
	} mmu_result_t;

	// resolved store, physical
	typedef struct packed {
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] data;
	} mem_req_t;

	typedef struct packed {
		logic            req;
		logic            we;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
	} dbus_req_t;

	typedef struct packed {
		logic            ready;
		logic [XLEN-1:0] rdata;
	} dbus_resp_t;

endpackage

// File: rtl/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit import lsu_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            flush,
	input  rs_entry_t       entry,
	input  logic            mmu_grant,
	input  mmu_result_t     mmu_result,
	input  logic            dbus_grant,
	input  dbus_resp_t      dbus_resp,
	input  logic            data_ack,
	output logic            mmu_req,
	output logic [XLEN-1:0] vaddr,
	output dbus_req_t       bus_req,
	output exc_code_t       ex,
	output mem_req_t        memreq,
	output logic [XLEN-1:0] data,
	output logic            data_ready
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_TRANSLATE,
		S_BUS,
		S_DONE
	} state_t;

	state_t state_q;
	state_t resolve_state;
	exc_code_t exc_next;
	logic operands_ok;
	logic granted;

	exc_code_t ex_q;
	mem_req_t memreq_q;
	logic [XLEN-1:0] data_q;

	assign operands_ok = entry.busy && entry.base.ready &&
		(!entry.is_store || entry.sdata.ready);
	assign vaddr = entry.base.value + XLEN'(entry.offset);

	// requests from the first cycle the operands are there
	assign mmu_req = (state_q == S_IDLE && operands_ok) || state_q == S_TRANSLATE;
	assign granted = mmu_req && mmu_grant;

	// misaligned wins over a page fault
	always_comb begin
		resolve_state = S_DONE;
		if (vaddr[1:0] != 2'b00) begin
			exc_next = exc_misaligned;
		end else if (mmu_result.fault) begin
			exc_next = exc_page_fault;
		end else begin
			exc_next = exc_none;
			if (!entry.is_store)
				resolve_state = S_BUS;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE, S_TRANSLATE: begin
					if (granted)
						state_q <= resolve_state;
					else if (mmu_req)
						state_q <= S_TRANSLATE;
				end
				S_BUS: begin
					if (dbus_grant)
						state_q <= S_DONE;
				end
				S_DONE: begin
					if (data_ack)
						state_q <= S_IDLE;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (granted) begin
			ex_q          <= exc_next;
			memreq_q.addr <= mmu_result.paddr;
			memreq_q.data <= entry.sdata.value;
			data_q        <= '0;
		end
		if (state_q == S_BUS && dbus_grant)
			data_q <= dbus_resp.rdata;
	end

	// word reads only
	assign bus_req = '{req: state_q == S_BUS, we: 1'b0, addr: memreq_q.addr, wdata: '0};

	assign ex         = ex_q;
	assign memreq     = memreq_q;
	assign data       = data_q;
	assign data_ready = state_q == S_DONE;

endmodule

// File: rtl/store_buffer.sv
`timescale 1ns/1ns

module store_buffer import lsu_pkg::*; #(
	parameter int STORE_DEPTH = 4
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      push,
	input  mem_req_t  memreq,
	input  logic      pop,
	output dbus_req_t bus_req,
	output logic      full,
	output logic      empty
);

	localparam int PTR_W = $clog2(STORE_DEPTH);
	localparam int CNT_W = $clog2(STORE_DEPTH + 1);

	mem_req_t mem [STORE_DEPTH];
	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [CNT_W-1:0] count_q;
	logic do_push;
	logic do_pop;
	mem_req_t head_item;

	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
		return (p == PTR_W'(STORE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full    = count_q == CNT_W'(STORE_DEPTH);
	assign empty   = count_q == '0;
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// head goes out as a write while anything is queued
	assign head_item = mem[head_q];
	assign bus_req   = '{req: !empty, we: 1'b1, addr: head_item.addr, wdata: head_item.data};

	always_ff @(posedge clk) begin
		if (do_push)
			mem[tail_q] <= memreq;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (do_push)
				tail_q <= next_ptr(tail_q);
			if (do_pop)
				head_q <= next_ptr(head_q);
			count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

endmodule

// File: rtl/dbus_arbiter.sv
`timescale 1ns/1ns

module dbus_arbiter import lsu_pkg::*; #(
	parameter int RS_SIZE = 4
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  dbus_req_t               store_req,
	input  dbus_req_t [RS_SIZE-1:0] load_req,
	input  dbus_resp_t              dbus_resp,
	output dbus_req_t               dbus_req,
	output logic                    store_pop,
	output logic [RS_SIZE-1:0]      load_grant
);

	localparam int IDX_W = $clog2(RS_SIZE);

	logic busy_q;
	logic owner_store_q;
	logic [IDX_W-1:0] owner_idx_q;
	dbus_req_t held_q;

	logic pick_valid;
	logic pick_store;
	logic [IDX_W-1:0] pick_idx;
	dbus_req_t pick_req;
	logic active;
	logic cur_store;
	logic [IDX_W-1:0] cur_idx;

	// store buffer first, then highest load
	always_comb begin
		pick_valid = 1'b0;
		pick_store = 1'b0;
		pick_idx   = '0;
		pick_req   = '0;
		if (store_req.req) begin
			pick_valid = 1'b1;
			pick_store = 1'b1;
			pick_req   = store_req;
		end else begin
			for (int i = 0; i < RS_SIZE; i++) begin
				if (load_req[i].req) begin
					pick_valid = 1'b1;
					pick_idx   = IDX_W'(i);
					pick_req   = load_req[i];
				end
			end
		end
	end

	// held copy keeps the bus stable even if the owner drops its request
	assign active    = busy_q || pick_valid;
	assign cur_store = busy_q ? owner_store_q : pick_store;
	assign cur_idx   = busy_q ? owner_idx_q : pick_idx;
	assign dbus_req  = busy_q ? held_q : pick_req;

	always_comb begin
		store_pop  = active && cur_store && dbus_resp.ready;
		load_grant = '0;
		if (active && !cur_store && dbus_resp.ready)
			load_grant[cur_idx] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q        <= 1'b0;
			owner_store_q <= 1'b0;
			owner_idx_q   <= '0;
		end else if (active && dbus_resp.ready) begin
			busy_q <= 1'b0;
		end else if (!busy_q && pick_valid) begin
			busy_q        <= 1'b1;
			owner_store_q <= pick_store;
			owner_idx_q   <= pick_idx;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy_q && pick_valid)
			held_q <= pick_req;
	end

endmodule

// File: rtl/lsu_rs.sv
`timescale 1ns/1ns

module lsu_rs import lsu_pkg::*; #(
	parameter int RS_SIZE     = 4,
	parameter int STORE_DEPTH = 4
) (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                flush,
	input  logic [1:0]                          rs_taken,
	input  rs_entry_t [1:0]                     rs_entry,
	output logic [1:0]                          rs_ready,
	output logic [1:0][$clog2(RS_SIZE)-1:0]     rs_index,
	input  cdb_packet_t                         cdb,
	output logic [XLEN-1:0]                     mmu_vaddr,
	input  mmu_result_t                         mmu_result,
	output exc_code_t [RS_SIZE-1:0]             ex,
	output mem_req_t [RS_SIZE-1:0]              memreq,
	output logic [RS_SIZE-1:0][XLEN-1:0]        data,
	output logic [RS_SIZE-1:0]                  data_ready,
	output rob_tag_t [RS_SIZE-1:0]              data_reorder,
	input  logic [RS_SIZE-1:0]                  data_ack,
	input  logic                                store_push,
	input  mem_req_t                            store_memreq,
	output logic                                store_full,
	output dbus_req_t                           dbus_req,
	input  dbus_resp_t                          dbus_resp
);

	localparam int IDX_W = $clog2(RS_SIZE);

	rs_entry_t [RS_SIZE-1:0] rs_q;
	rs_entry_t [RS_SIZE-1:0] rs_n;
	logic [1:0] rs_ready_n;
	logic [1:0][IDX_W-1:0] rs_index_n;

	logic [RS_SIZE-1:0] unit_mmu_req;
	logic [RS_SIZE-1:0] unit_mmu_grant;
	logic [RS_SIZE-1:0][XLEN-1:0] unit_vaddr;
	dbus_req_t [RS_SIZE-1:0] unit_bus_req;
	logic [RS_SIZE-1:0] unit_bus_grant;
	dbus_req_t store_bus_req;
	logic store_pop;

	function automatic operand_t capture(operand_t op, cdb_packet_t pkt);
		operand_t res;
		res = op;
		if (!op.ready && pkt.valid && pkt.tag == op.tag) begin
			res.ready = 1'b1;
			res.value = pkt.value;
		end
		return res;
	endfunction

	// capture, then pop, then push
	always_comb begin
		rs_n = rs_q;
		for (int i = 0; i < RS_SIZE; i++) begin
			if (rs_q[i].busy) begin
				rs_n[i].base  = capture(rs_q[i].base, cdb);
				rs_n[i].sdata = capture(rs_q[i].sdata, cdb);
			end
			if (data_ack[i])
				rs_n[i] = '0;
		end
		for (int k = 0; k < 2; k++) begin
			if (rs_taken[k]) begin
				rs_n[rs_index[k]] = rs_entry[k];
				rs_n[rs_index[k]].busy = 1'b1;
			end
		end
	end

	// two highest free indices
	always_comb begin
		rs_ready_n = '0;
		rs_index_n = '0;
		for (int i = 0; i < RS_SIZE; i++) begin
			if (!rs_n[i].busy) begin
				rs_ready_n[0] = 1'b1;
				rs_index_n[0] = IDX_W'(i);
			end
		end
		for (int i = 0; i < RS_SIZE; i++) begin
			if (!rs_n[i].busy && !(rs_ready_n[0] && rs_index_n[0] == IDX_W'(i))) begin
				rs_ready_n[1] = 1'b1;
				rs_index_n[1] = IDX_W'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			rs_q        <= '0;
			rs_ready    <= 2'b11;
			rs_index[0] <= IDX_W'(0);
			rs_index[1] <= IDX_W'(1);
		end else begin
			rs_q     <= rs_n;
			rs_ready <= rs_ready_n;
			rs_index <= rs_index_n;
		end
	end

	// fixed priority, highest index wins
	always_comb begin
		mmu_vaddr      = '0;
		unit_mmu_grant = '0;
		for (int i = 0; i < RS_SIZE; i++) begin
			if (unit_mmu_req[i]) begin
				mmu_vaddr         = unit_vaddr[i];
				unit_mmu_grant    = '0;
				unit_mmu_grant[i] = 1'b1;
			end
		end
	end

	for (genvar i = 0; i < RS_SIZE; i++) begin : gen_unit
		assign data_reorder[i] = rs_q[i].dest;

		load_store_unit unit_i (
			.clk        (clk),
			.rst_n      (rst_n),
			.flush      (flush),
			.entry      (rs_q[i]),
			.mmu_grant  (unit_mmu_grant[i]),
			.mmu_result (mmu_result),
			.dbus_grant (unit_bus_grant[i]),
			.dbus_resp  (dbus_resp),
			.data_ack   (data_ack[i]),
			.mmu_req    (unit_mmu_req[i]),
			.vaddr      (unit_vaddr[i]),
			.bus_req    (unit_bus_req[i]),
			.ex         (ex[i]),
			.memreq     (memreq[i]),
			.data       (data[i]),
			.data_ready (data_ready[i])
		);
	end

	store_buffer #(
		.STORE_DEPTH (STORE_DEPTH)
	) store_buffer_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.push    (store_push),
		.memreq  (store_memreq),
		.pop     (store_pop),
		.bus_req (store_bus_req),
		.full    (store_full),
		.empty   ()
	);

	dbus_arbiter #(
		.RS_SIZE (RS_SIZE)
	) dbus_arbiter_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.store_req  (store_bus_req),
		.load_req   (unit_bus_req),
		.dbus_resp  (dbus_resp),
		.dbus_req   (dbus_req),
		.store_pop  (store_pop),
		.load_grant (unit_bus_grant)
	);

endmodule

// File: test/lsu_rs_props.sv
`timescale 1ns/1ns

module lsu_rs_props import lsu_pkg::*; #(
	parameter int RS_SIZE = 4
) (
	input logic                                clk,
	input logic                                rst_n,
	input logic                                flush,
	input logic [1:0]                          rs_ready,
	input logic [1:0][$clog2(RS_SIZE)-1:0]     rs_index,
	input logic [RS_SIZE-1:0]                  data_ready,
	input logic [RS_SIZE-1:0]                  data_ack,
	input logic [RS_SIZE-1:0]                  unit_mmu_req,
	input logic [RS_SIZE-1:0]                  unit_mmu_grant,
	input logic                                store_full,
	input dbus_req_t                           dbus_req,
	input dbus_resp_t                          dbus_resp
);

	int fail_count = 0;

	// clean state one cycle after reset or flush
	a_clear: assert property (@(posedge clk) (!rst_n || flush) |=>
		rs_ready == 2'b11 && rs_index[0] == '0 && rs_index[1] == 1 && data_ready == '0)
		else begin
			$error("station not cleared after reset or flush");
			fail_count++;
		end

	a_reset_bus: assert property (@(posedge clk) !rst_n |=> !dbus_req.req && !store_full)
		else begin
			$error("bus request or store_full high after reset");
			fail_count++;
		end

	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		dbus_req.req && !dbus_resp.ready |=> dbus_req.req && $stable(dbus_req))
		else begin
			$error("data bus request changed before ready");
			fail_count++;
		end

	// one grant, only to a requester, and only when someone asks
	a_mmu_grant: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(unit_mmu_grant) && (unit_mmu_grant & ~unit_mmu_req) == '0 &&
		(|unit_mmu_grant) == (|unit_mmu_req))
		else begin
			$error("MMU grant not given to exactly one requester");
			fail_count++;
		end

	// no requester above the granted unit
	a_mmu_prio: assert property (@(posedge clk) disable iff (!rst_n)
		|unit_mmu_req |-> {1'b0, unit_mmu_req} < {unit_mmu_grant, 1'b0})
		else begin
			$error("MMU grant skipped a higher requester");
			fail_count++;
		end

	// a flushed load still finishes its bus cycle
	a_flush_load: assert property (@(posedge clk) disable iff (!rst_n)
		flush && dbus_req.req && !dbus_req.we |-> ##[0:8] dbus_resp.ready)
		else begin
			$error("load bus cycle did not end after flush");
			fail_count++;
		end

	for (genvar i = 0; i < RS_SIZE; i++) begin : gen_hold
		a_ready_hold: assert property (@(posedge clk) disable iff (!rst_n || flush)
			data_ready[i] && !data_ack[i] |=> data_ready[i])
			else begin
				$error("data_ready dropped before data_ack");
				fail_count++;
			end
	end

endmodule

bind lsu_rs lsu_rs_props #(.RS_SIZE(RS_SIZE)) props_i (
	.clk            (clk),
	.rst_n          (rst_n),
	.flush          (flush),
	.rs_ready       (rs_ready),
	.rs_index       (rs_index),
	.data_ready     (data_ready),
	.data_ack       (data_ack),
	.unit_mmu_req   (unit_mmu_req),
	.unit_mmu_grant (unit_mmu_grant),
	.store_full     (store_full),
	.dbus_req       (dbus_req),
	.dbus_resp      (dbus_resp)
);

// File: test/lsu_rs_tb.sv
`timescale 1ns/1ns

module lsu_rs_tb import lsu_pkg::*;;

	localparam int RS_SIZE     = 4;
	localparam int STORE_DEPTH = 4;
	localparam int NUM_OPS     = 30;

	logic clk;
	logic rst_n;
	logic flush;
	logic [1:0] rs_taken;
	rs_entry_t [1:0] rs_entry;
	logic [1:0] rs_ready;
	logic [1:0][$clog2(RS_SIZE)-1:0] rs_index;
	cdb_packet_t cdb;
	logic [XLEN-1:0] mmu_vaddr;
	mmu_result_t mmu_result;
	exc_code_t [RS_SIZE-1:0] ex;
	mem_req_t [RS_SIZE-1:0] memreq;
	logic [RS_SIZE-1:0][XLEN-1:0] data;
	logic [RS_SIZE-1:0] data_ready;
	rob_tag_t [RS_SIZE-1:0] data_reorder;
	logic [RS_SIZE-1:0] data_ack;
	logic store_push;
	mem_req_t store_memreq;
	logic store_full;
	dbus_req_t dbus_req;
	dbus_resp_t dbus_resp;

	int seed = 32'he8ea_d341;
	int errors = 0;
	int checks = 0;
	int pending = 0;
	int delay;
	bit in_flight;
	logic stall;
	logic waiting_cdb;
	logic [31:0] stale_vaddr;
	rob_tag_t next_tag = '0;
	rob_tag_t tag;
	mem_req_t commit_item;

	// scoreboard keyed by rob tag
	bit expected [32];
	bit exp_store [32];
	exc_code_t exp_ex [32];
	logic [31:0] exp_data [32];
	mem_req_t exp_req [32];
	mem_req_t commit_q [$];
	mem_req_t exp_writes [$];
	bit read_seen [logic [31:0]];

	lsu_rs #(.RS_SIZE(RS_SIZE), .STORE_DEPTH(STORE_DEPTH)) lsu_rs_i (.*);

	// mmu: fixed page offset, upper half faults
	assign mmu_result = '{paddr: mmu_vaddr ^ 32'h0000_1000, fault: mmu_vaddr[31]};

	function automatic logic [31:0] word_at(logic [31:0] a);
		return (a * 32'h9e37_79b1) ^ {a[7:0], a[31:8]};
	endfunction

	task automatic report_mismatch(string name, logic [31:0] exp_v, logic [31:0] act_v);
		$display("Fail %s: expected %h, got %h", name, exp_v, act_v);
		errors++;
	endtask

	task automatic report_error(string msg);
		$display("%s", msg);
		errors++;
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(NUM_OPS * 40 * 10);
		$display("watchdog expired with %0d results outstanding", pending);
		$display("TESTS FAILED");
		$finish;
	end

	// memory answers after 0 to 3 cycles
	always @(posedge clk) begin
		dbus_resp.ready <= 1'b0;
		if (!rst_n) begin
			in_flight = 1'b0;
		end else if (!dbus_resp.ready && dbus_req.req && !stall) begin
			if (!in_flight) begin
				in_flight = 1'b1;
				delay = $unsigned($random(seed)) % 4;
			end
			if (delay == 0) begin
				in_flight = 1'b0;
				dbus_resp <= '{ready: 1'b1, rdata: word_at(dbus_req.addr)};
				if (dbus_req.we)
					check_write(dbus_req);
				else
					read_seen[dbus_req.addr] = 1'b1;
			end else begin
				delay--;
			end
		end
	end

	task automatic check_write(dbus_req_t r);
		mem_req_t e;
		if (exp_writes.size() == 0) begin
			report_error("write on the data bus with no committed store");
		end else begin
			e = exp_writes.pop_front();
			assert (r.addr == e.addr) else report_mismatch("dbus_req.addr", e.addr, r.addr);
			assert (r.wdata == e.data) else report_mismatch("dbus_req.wdata", e.data, r.wdata);
		end
	endtask

	task automatic check_result(int i);
		rob_tag_t t;
		t = data_reorder[i];
		checks++;
		if (!expected[t]) begin
			report_error($sformatf("result for tag %0d that was not expected", t));
		end else begin
			expected[t] = 1'b0;
			pending--;
			assert (ex[i] == exp_ex[t]) else report_mismatch("ex", exp_ex[t], ex[i]);
			if (exp_ex[t] != exc_none) begin
				if (read_seen.exists(exp_req[t].addr))
					report_error($sformatf("faulting tag %0d made a bus read", t));
			end else if (exp_store[t]) begin
				assert (memreq[i].addr == exp_req[t].addr)
				else report_mismatch("memreq.addr", exp_req[t].addr, memreq[i].addr);
				assert (memreq[i].data == exp_req[t].data)
				else report_mismatch("memreq.data", exp_req[t].data, memreq[i].data);
				commit_q.push_back(exp_req[t]);
			end else begin
				assert (data[i] == exp_data[t]) else report_mismatch("data", exp_data[t], data[i]);
			end
		end
	endtask

	always @(posedge clk) begin
		data_ack <= '0;
		if (rst_n) begin
			for (int i = 0; i < RS_SIZE; i++) begin
				if (data_ready[i] && !data_ack[i]) begin
					check_result(i);
					data_ack[i] <= 1'b1;
				end
			end
		end
	end

	// commit at most every other cycle so store_full is current
	always @(posedge clk) begin
		store_push <= 1'b0;
		if (rst_n && commit_q.size() > 0 && !store_full && !store_push) begin
			commit_item = commit_q.pop_front();
			store_push <= 1'b1;
			store_memreq <= commit_item;
			exp_writes.push_back(commit_item);
		end
	end

	a_no_early_mmu: assert property (@(posedge clk) disable iff (!rst_n)
		waiting_cdb |-> mmu_vaddr != stale_vaddr)
	else report_error("load requested the MMU before its base came on the cdb");

	task automatic issue(logic [31:0] base, logic base_ok, logic [15:0] off, logic st,
			logic [31:0] sdata, logic [31:0] real_base);
		rs_entry_t e;
		logic [31:0] va;
		tag = next_tag;
		next_tag = (next_tag == 5'd30) ? '0 : next_tag + 1'b1;
		va = real_base + {{16{off[15]}}, off};
		if (va[1:0] != 2'b00)
			exp_ex[tag] = exc_misaligned;
		else if (va[31])
			exp_ex[tag] = exc_page_fault;
		else
			exp_ex[tag] = exc_none;
		exp_req[tag] = '{addr: va ^ 32'h0000_1000, data: sdata};
		exp_data[tag] = word_at(va ^ 32'h0000_1000);
		exp_store[tag] = st;
		expected[tag] = 1'b1;
		pending++;
		e = '0;
		e.is_store = st;
		e.base = '{ready: base_ok, tag: 5'd31, value: base};
		e.sdata = '{ready: 1'b1, tag: '0, value: sdata};
		e.offset = off;
		e.dest = tag;
		do @(negedge clk); while (!rs_ready[0]);
		@(posedge clk);
		rs_taken <= 2'b01;
		rs_entry[0] <= e;
		@(posedge clk);
		rs_taken <= 2'b00;
	endtask

	task automatic random_op(logic st);
		logic [31:0] b;
		@(negedge clk);
		b = $random(seed) & 32'h7fff_fffc;
		issue(b, 1'b1, 16'($random(seed)) & 16'hfffc, st, $random(seed), b);
	endtask

	task automatic wait_idle();
		while (pending != 0 || commit_q.size() != 0 || exp_writes.size() != 0)
			@(negedge clk);
	endtask

	initial begin
		rst_n = 1'b0;
		flush = 1'b0;
		rs_taken = '0;
		rs_entry = '0;
		cdb = '0;
		data_ack = '0;
		store_push = 1'b0;
		store_memreq = '0;
		dbus_resp = '0;
		stall = 1'b0;
		waiting_cdb = 1'b0;
		stale_vaddr = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		for (int n = 0; n < 12; n++)
			random_op(1'b0);
		wait_idle();

		// load waits for its base on the cdb
		stale_vaddr = 32'h0000_0340 + 32'h10;
		issue(32'h0000_0340, 1'b0, 16'h0010, 1'b0, '0, 32'h0002_4a80);
		waiting_cdb <= 1'b1;
		repeat (5) @(posedge clk);
		cdb <= '{valid: 1'b1, tag: 5'd31, value: 32'h0002_4a80};
		waiting_cdb <= 1'b0;
		@(posedge clk);
		cdb <= '0;
		wait_idle();

		issue(32'h8000_1000, 1'b1, 16'h0000, 1'b0, '0, 32'h8000_1000);
		issue(32'h8000_1000, 1'b1, 16'h0001, 1'b0, '0, 32'h8000_1000);
		issue(32'h0000_2000, 1'b1, 16'h0002, 1'b1, 32'h1234_5678, 32'h0000_2000);
		wait_idle();

		for (int n = 0; n < 6; n++)
			random_op(n[0]);
		wait_idle();

		// stalled bus fills the store buffer
		stall <= 1'b1;
		for (int n = 0; n < STORE_DEPTH; n++)
			random_op(1'b1);
		while (exp_writes.size() < STORE_DEPTH)
			@(negedge clk);
		@(negedge clk);
		@(negedge clk);
		assert (store_full) else report_mismatch("store_full", 32'h1, {31'h0, store_full});
		stall <= 1'b0;
		wait_idle();

		// flush while a load sits on the bus
		stall <= 1'b1;
		issue(32'h0000_5000, 1'b1, 16'h0004, 1'b0, '0, 32'h0000_5000);
		do @(negedge clk); while (!(dbus_req.req && !dbus_req.we));
		@(posedge clk);
		flush <= 1'b1;
		expected[tag] = 1'b0;
		pending--;
		@(posedge clk);
		flush <= 1'b0;
		stall <= 1'b0;
		repeat (10) @(posedge clk);

		$display("checks: %0d, errors: %0d, property failures: %0d", checks, errors,
			lsu_rs_i.props_i.fail_count);
		if (errors == 0 && lsu_rs_i.props_i.fail_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: lsu_rs.f
rtl/lsu_pkg.sv
rtl/load_store_unit.sv
rtl/store_buffer.sv
rtl/dbus_arbiter.sv
rtl/lsu_rs.sv
test/lsu_rs_props.sv
test/lsu_rs_tb.sv
